//--- src/noc_pkg.sv
package noc_pkg;

  // Flit and mesh geometry.
  localparam int FLIT_WIDTH  = 16;
  localparam int COORD_WIDTH = 2;
  localparam int TAG_WIDTH   = 8;
  localparam int NUM_PORTS   = 5;

  // Width of a port index, wide enough for NUM_PORTS entries.
  localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);

  // Router port numbering, shared by every port-indexed vector.
  typedef enum logic [PORT_IDX_WIDTH-1:0] {
    XP    = 3'd0,
    XM    = 3'd1,
    YP    = 3'd2,
    YM    = 3'd3,
    LOCAL = 3'd4
  } noc_port_e;

  // Header flit layout, destination in the upper bits.
  typedef struct packed {
    logic [COORD_WIDTH-1:0] dest_x;
    logic [COORD_WIDTH-1:0] dest_y;
    logic [COORD_WIDTH-1:0] src_x;
    logic [COORD_WIDTH-1:0] src_y;
    logic [TAG_WIDTH-1:0]   tag;
  } noc_header_t;

  // One flit word, read as a header at packet start and as payload afterwards.
  typedef union packed {
    noc_header_t           header;
    logic [FLIT_WIDTH-1:0] data;
  } noc_flit_u;

endpackage

//--- src/noc_input_port.sv
`timescale 1ns/10ps

module noc_input_port #(
  parameter logic [noc_pkg::COORD_WIDTH-1:0] X = '0,
  parameter logic [noc_pkg::COORD_WIDTH-1:0] Y = '0,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [noc_pkg::FLIT_WIDTH-1:0]  in_data,
  input  logic                            in_last,
  output logic [noc_pkg::NUM_PORTS-1:0]   route_req,
  output logic [noc_pkg::FLIT_WIDTH-1:0]  head_data,
  output logic                            head_last,
  input  logic [noc_pkg::NUM_PORTS-1:0]   grant,
  input  logic [noc_pkg::NUM_PORTS-1:0]   pop
);
  import noc_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [FLIT_WIDTH:0]  mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic [CNT_W-1:0]     avail;
  logic                 push;
  logic                 push_q;
  logic                 pop_fire;
  logic                 head_valid;
  noc_flit_u            head_flit;
  logic [NUM_PORTS-1:0] route_dec;
  logic [NUM_PORTS-1:0] route_q;
  logic [NUM_PORTS-1:0] route_cur;
  logic                 locked;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready = (count != CNT_W'(FIFO_DEPTH));
  assign push     = in_valid && in_ready;

  // Only the output that holds our grant can pop us.
  assign pop_fire = |(grant & pop);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_last, in_data};
    end
  end

  // count tracks occupancy for in_ready.
  // avail lags writes by one cycle and gates the head.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      avail  <= '0;
      push_q <= 1'b0;
    end else begin
      push_q <= push;
      count  <= count + CNT_W'(push) - CNT_W'(pop_fire);
      avail  <= avail + CNT_W'(push_q) - CNT_W'(pop_fire);
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
    end
  end

  assign head_valid = (avail != '0);
  assign head_data  = mem[rd_ptr][FLIT_WIDTH-1:0];
  assign head_last  = mem[rd_ptr][FLIT_WIDTH];
  assign head_flit  = head_data;

  // XY order: X is resolved before Y.
  always_comb begin
    route_dec = '0;
    if (head_flit.header.dest_x > X) begin
      route_dec[XP] = 1'b1;
    end else if (head_flit.header.dest_x < X) begin
      route_dec[XM] = 1'b1;
    end else if (head_flit.header.dest_y > Y) begin
      route_dec[YP] = 1'b1;
    end else if (head_flit.header.dest_y < Y) begin
      route_dec[YM] = 1'b1;
    end else begin
      route_dec[LOCAL] = 1'b1;
    end
  end

  // The header sets the route, payload flits reuse it.
  always_ff @(posedge clk) begin
    if (reset) begin
      locked  <= 1'b0;
      route_q <= '0;
    end else if (pop_fire) begin
      locked <= !head_last;
      if (!locked) begin
        route_q <= route_dec;
      end
    end
  end

  assign route_cur = locked ? route_q : route_dec;
  assign route_req = head_valid ? route_cur : '0;

endmodule

//--- src/noc_output_arbiter.sv
`timescale 1ns/10ps

module noc_output_arbiter (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       req,
  output logic [noc_pkg::NUM_PORTS-1:0]                       grant,
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] flit_in,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       last_in,
  output logic                                                fwd_valid,
  output logic [noc_pkg::FLIT_WIDTH-1:0]                      fwd_data,
  output logic                                                fwd_last,
  input  logic                                                fwd_ready
);
  import noc_pkg::*;

  localparam int IDX_W = PORT_IDX_WIDTH;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] owner_q;
  logic             locked_q;
  logic [IDX_W-1:0] pick;
  logic             pick_found;
  logic [IDX_W-1:0] winner;
  logic             active;
  logic             xfer;

  function automatic logic [IDX_W-1:0] wrap_add(input logic [IDX_W-1:0] base,
                                                input int offset);
    int sum;
    sum = int'(base) + offset;
    if (sum >= NUM_PORTS) begin
      sum = sum - NUM_PORTS;
    end
    return IDX_W'(sum);
  endfunction

  // First requester at or after the pointer wins.
  always_comb begin
    pick       = ptr_q;
    pick_found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      if (!pick_found && req[wrap_add(ptr_q, k)]) begin
        pick       = wrap_add(ptr_q, k);
        pick_found = 1'b1;
      end
    end
  end

  // A locked output waits on its owner, even when the owner's FIFO runs dry.
  assign winner = locked_q ? owner_q : pick;
  assign active = locked_q ? req[owner_q] : pick_found;

  assign grant     = active ? (NUM_PORTS'(1) << winner) : '0;
  assign fwd_valid = active;
  assign fwd_data  = flit_in[winner];
  assign fwd_last  = last_in[winner];

  assign xfer = fwd_valid && fwd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q    <= '0;
      owner_q  <= '0;
      locked_q <= 1'b0;
    end else if (xfer) begin
      if (fwd_last) begin
        locked_q <= 1'b0;
        ptr_q    <= wrap_add(winner, 1);
      end else begin
        locked_q <= 1'b1;
        owner_q  <= winner;
      end
    end
  end

endmodule

//--- src/noc_output_stage.sv
`timescale 1ns/10ps

module noc_output_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           fwd_valid,
  input  logic [noc_pkg::FLIT_WIDTH-1:0] fwd_data,
  input  logic                           fwd_last,
  output logic                           fwd_ready,
  output logic                           out_valid,
  output logic [noc_pkg::FLIT_WIDTH-1:0] out_data,
  output logic                           out_last,
  input  logic                           out_ready
);
  import noc_pkg::*;

  logic                  valid_q;
  logic [FLIT_WIDTH-1:0] data_q;
  logic                  last_q;

  // Ready while empty or while the held flit leaves this cycle.
  assign fwd_ready = !valid_q || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (fwd_ready) begin
      valid_q <= fwd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd_ready && fwd_valid) begin
      data_q <= fwd_data;
      last_q <= fwd_last;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;
  assign out_last  = last_q;

endmodule

//--- src/noc_router.sv
`timescale 1ns/10ps

module noc_router #(
  parameter logic [noc_pkg::COORD_WIDTH-1:0] X = '0,
  parameter logic [noc_pkg::COORD_WIDTH-1:0] Y = '0,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       in_valid,
  output logic [noc_pkg::NUM_PORTS-1:0]                       in_ready,
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] in_data,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       in_last,
  output logic [noc_pkg::NUM_PORTS-1:0]                       out_valid,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       out_ready,
  output logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] out_data,
  output logic [noc_pkg::NUM_PORTS-1:0]                       out_last
);
  import noc_pkg::*;

  // Request and grant matrices, first index named in the trailing comment.
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  route_req;  // input
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  arb_req;    // output
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  arb_grant;  // output
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  in_grant;   // input
  logic [NUM_PORTS-1:0][FLIT_WIDTH-1:0] head_data;
  logic [NUM_PORTS-1:0]                 head_last;
  logic [NUM_PORTS-1:0]                 fwd_valid;
  logic [NUM_PORTS-1:0][FLIT_WIDTH-1:0] fwd_data;
  logic [NUM_PORTS-1:0]                 fwd_last;
  logic [NUM_PORTS-1:0]                 fwd_ready;
  logic [NUM_PORTS-1:0]                 xfer;

  // A flit moves through output o when its stage accepts it.
  assign xfer = fwd_valid & fwd_ready;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xbar_row
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xbar_col
      assign arb_req[o][i]  = route_req[i][o];
      assign in_grant[i][o] = arb_grant[o][i];
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    noc_input_port #(
      .X          (X         ),
      .Y          (Y         ),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in (
      .clk       (clk         ),
      .reset     (reset       ),
      .in_valid  (in_valid[p] ),
      .in_ready  (in_ready[p] ),
      .in_data   (in_data[p]  ),
      .in_last   (in_last[p]  ),
      .route_req (route_req[p]),
      .head_data (head_data[p]),
      .head_last (head_last[p]),
      .grant     (in_grant[p] ),
      .pop       (xfer        )
    );

    noc_output_arbiter u_arb (
      .clk       (clk         ),
      .reset     (reset       ),
      .req       (arb_req[p]  ),
      .grant     (arb_grant[p]),
      .flit_in   (head_data   ),
      .last_in   (head_last   ),
      .fwd_valid (fwd_valid[p]),
      .fwd_data  (fwd_data[p] ),
      .fwd_last  (fwd_last[p] ),
      .fwd_ready (fwd_ready[p])
    );

    noc_output_stage u_out (
      .clk       (clk         ),
      .reset     (reset       ),
      .fwd_valid (fwd_valid[p]),
      .fwd_data  (fwd_data[p] ),
      .fwd_last  (fwd_last[p] ),
      .fwd_ready (fwd_ready[p]),
      .out_valid (out_valid[p]),
      .out_data  (out_data[p] ),
      .out_last  (out_last[p] ),
      .out_ready (out_ready[p])
    );
  end

endmodule

//--- test/noc_router_props.sv
`timescale 1ns/10ps

module noc_router_props #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                                                  clk,
  input logic                                                  reset,
  input logic [noc_pkg::NUM_PORTS-1:0]                         in_valid,
  input logic [noc_pkg::NUM_PORTS-1:0]                         in_ready,
  input logic [noc_pkg::NUM_PORTS-1:0]                         out_valid,
  input logic [noc_pkg::NUM_PORTS-1:0]                         out_ready,
  input logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] out_data,
  input logic [noc_pkg::NUM_PORTS-1:0]                         out_last,
  input logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] in_grant,
  input logic [noc_pkg::NUM_PORTS-1:0]                         xfer
);
  import noc_pkg::*;

  // Input FIFO fill level, rebuilt from pushes and pops seen at the boundary.
  int occ [NUM_PORTS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        occ[p] <= 0;
      end
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        occ[p] <= occ[p] + int'(in_valid[p] && in_ready[p]) - int'(|(in_grant[p] & xfer));
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) reset |=> out_valid == '0)
    else $error("out_valid high after reset");

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // A stalled output keeps its flit.
    a_hold: assert property (@(posedge clk) disable iff (reset)
      out_valid[p] && !out_ready[p] |=>
        out_valid[p] && $stable(out_data[p]) && $stable(out_last[p]))
      else $error("output %0d changed while stalled", p);

    a_ready: assert property (@(posedge clk) disable iff (reset)
      occ[p] < FIFO_DEPTH |-> in_ready[p])
      else $error("input %0d not ready although its FIFO has space", p);
  end

endmodule

bind noc_router noc_router_props #(
  .FIFO_DEPTH (FIFO_DEPTH)
) props0 (
  .clk       (clk      ),
  .reset     (reset    ),
  .in_valid  (in_valid ),
  .in_ready  (in_ready ),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data ),
  .out_last  (out_last ),
  .in_grant  (in_grant ),
  .xfer      (xfer     )
);

//--- test/tb_top.sv
`timescale 1ns/10ps

module tb_top;
  import noc_pkg::*;

  localparam logic [COORD_WIDTH-1:0] RX = 2'd1;
  localparam logic [COORD_WIDTH-1:0] RY = 2'd1;
  localparam int FIFO_DEPTH   = 4;
  localparam int MAX_TESTS    = 32;
  localparam int MAX_FLITS    = 32;
  localparam int STALL_CYCLES = 16;
  localparam int DRAIN_CYCLES = 4;

  logic                                 clk;
  logic                                 reset;
  logic [NUM_PORTS-1:0]                 in_valid;
  logic [NUM_PORTS-1:0]                 in_ready;
  logic [NUM_PORTS-1:0][FLIT_WIDTH-1:0] in_data;
  logic [NUM_PORTS-1:0]                 in_last;
  logic [NUM_PORTS-1:0]                 out_valid;
  logic [NUM_PORTS-1:0]                 out_ready;
  logic [NUM_PORTS-1:0][FLIT_WIDTH-1:0] out_data;
  logic [NUM_PORTS-1:0]                 out_last;

  // Six fields per test in file order.
  logic [7:0]            tests [MAX_TESTS*6];
  logic [FLIT_WIDTH-1:0] flits [NUM_PORTS][MAX_FLITS];
  int                    pk_src [NUM_PORTS];
  int                    sent [NUM_PORTS];
  int                    got [NUM_PORTS];
  int                    owner [NUM_PORTS];
  logic [31:0]           lcg_state;
  int                    pk_len;
  int                    npk;
  int                    exp_out;
  int                    done_cnt;
  int                    test_errors;
  int                    cyc;
  int                    cycle_limit;

  noc_router #(
    .X          (RX        ),
    .Y          (RY        ),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk       (clk      ),
    .reset     (reset    ),
    .in_valid  (in_valid ),
    .in_ready  (in_ready ),
    .in_data   (in_data  ),
    .in_last   (in_last  ),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data ),
    .out_last  (out_last )
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > cycle_limit) begin
      $display("Timeout after %0d cycles with packets still outstanding", cyc);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // X is resolved before Y and local delivery needs both to match.
  function automatic int xy_route(logic [COORD_WIDTH-1:0] dx, logic [COORD_WIDTH-1:0] dy);
    if (dx > RX) return int'(XP);
    if (dx < RX) return int'(XM);
    if (dy > RY) return int'(YP);
    if (dy < RY) return int'(YM);
    return int'(LOCAL);
  endfunction

  // The header tag names the packet and later flits follow it on the same output.
  task automatic take_flit(input int o, input int t);
    logic [FLIT_WIDTH-1:0] flit;
    int k;
    flit = out_data[o];
    if (owner[o] < 0) begin
      k = int'(flit[2:0]);
      if (flit[7:3] != t[4:0] || k >= npk || got[k] != 0) begin
        $display("Test %0d: output %0d sent a flit that starts no expected packet", t, o);
        test_errors++;
        return;
      end
      if (o != exp_out) begin
        $display("FAILED output port: expected 0x%0h got 0x%0h", exp_out, o);
        test_errors++;
      end
      owner[o] = k;
    end
    k = owner[o];
    if (flit !== flits[k][got[k]]) begin
      $display("FAILED out_data[%0d]: expected 0x%h got 0x%h", o, flits[k][got[k]], flit);
      test_errors++;
    end
    if (out_last[o] !== (got[k] == pk_len)) begin
      $display("FAILED out_last[%0d]: expected 0x%h got 0x%h", o, got[k] == pk_len, out_last[o]);
      test_errors++;
    end
    got[k]++;
    if (out_last[o] || got[k] > pk_len) begin
      owner[o] = -1;
      done_cnt++;
    end
  endtask

  initial begin
    int num_tests;
    int total;
    int errors;
    int failed_tests;
    int t;
    int j;
    int k;
    int port;
    int mode;
    int ncyc;
    int hdr_cyc;
    int first_cyc;
    logic [COORD_WIDTH-1:0] dx;
    logic [COORD_WIDTH-1:0] dy;
    logic [31:0] r;
    logic saw_full;
    reset = 1'b1;
    in_valid = '0;
    in_data = '0;
    in_last = '0;
    out_ready = '1;
    cyc = 0;
    errors = 0;
    failed_tests = 0;
    lcg_state = 32'd96535;
    for (int i = 0; i < MAX_TESTS * 6; i++) begin
      tests[i] = 8'hff;
    end
    $readmemh("test/router_tests.mem", tests);
    num_tests = 0;
    total = 0;
    while (num_tests < MAX_TESTS && tests[num_tests*6] != 8'hff) begin
      total += int'(tests[num_tests*6+5]) * (int'(tests[num_tests*6+3]) + 1);
      num_tests++;
    end
    cycle_limit = total * 8 + 100;
    if (num_tests == 0) begin
      $display("No tests could be read from the test file");
      errors++;
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (t = 0; t < num_tests; t++) begin
      port = int'(tests[t*6]);
      dx = tests[t*6+1][COORD_WIDTH-1:0];
      dy = tests[t*6+2][COORD_WIDTH-1:0];
      pk_len = int'(tests[t*6+3]);
      mode = int'(tests[t*6+4]);
      npk = int'(tests[t*6+5]);
      exp_out = xy_route(dx, dy);
      test_errors = 0;
      if (port >= NUM_PORTS || npk < 1 || npk > NUM_PORTS || pk_len >= MAX_FLITS) begin
        $display("Test %0d: fields in the test file are out of range", t);
        errors++;
        failed_tests++;
        continue;
      end
      // Packet j enters on the j-th port after the listed one.
      for (j = 0; j < npk; j++) begin
        pk_src[j] = (port + j) % NUM_PORTS;
        flits[j][0] = {dx, dy, t[1:0], j[1:0], t[4:0], j[2:0]};
        for (k = 1; k <= pk_len; k++) begin
          r = lcg_next();
          flits[j][k] = r[23:8];
        end
        sent[j] = 0;
        got[j] = 0;
      end
      for (j = 0; j < NUM_PORTS; j++) begin
        owner[j] = -1;
      end
      done_cnt = 0;
      ncyc = 0;
      hdr_cyc = -1;
      first_cyc = -1;
      saw_full = 1'b0;

      while (done_cnt < npk) begin
        @(negedge clk);
        ncyc++;
        for (j = 0; j < npk; j++) begin
          in_valid[pk_src[j]] = (sent[j] <= pk_len);
          in_data[pk_src[j]] = flits[j][sent[j]];
          in_last[pk_src[j]] = (sent[j] == pk_len);
        end
        for (j = 0; j < NUM_PORTS; j++) begin
          r = lcg_next();
          case (mode)
            1: out_ready[j] = r[16];
            2: out_ready[j] = (ncyc > STALL_CYCLES);
            default: out_ready[j] = 1'b1;
          endcase
        end
        // Inputs and outputs stay put until the next rising edge.
        for (j = 0; j < npk; j++) begin
          if (in_valid[pk_src[j]] && in_ready[pk_src[j]]) begin
            if (sent[j] == 0) begin
              hdr_cyc = ncyc;
            end
            sent[j]++;
          end else if (in_valid[pk_src[j]]) begin
            saw_full = 1'b1;
          end
        end
        for (j = 0; j < NUM_PORTS; j++) begin
          // An out_valid seen here rose at the rising edge before this one.
          if (out_valid[j] && first_cyc < 0) begin
            first_cyc = ncyc - 1;
          end
          if (out_valid[j] && out_ready[j]) begin
            take_flit(j, t);
          end
        end
      end

      if (mode == 0 && npk == 1 && first_cyc - hdr_cyc != 2) begin
        $display("FAILED out_valid latency: expected 0x2 got 0x%0h", first_cyc - hdr_cyc);
        test_errors++;
      end
      if (mode == 2 && !saw_full) begin
        $display("Test %0d: in_ready never dropped while the output was stalled", t);
        test_errors++;
      end
      $display("Test %0d: %0d packet(s) from port %0d to (%0d,%0d), %0d payload, %0d errors",
               t, npk, port, dx, dy, pk_len, test_errors);
      errors += test_errors;
      if (test_errors != 0) begin
        failed_tests++;
      end
    end

    // Every packet is complete, so no output may send anything more.
    out_ready = '1;
    for (j = 0; j < DRAIN_CYCLES; j++) begin
      @(negedge clk);
      if (out_valid != '0) begin
        $display("An output sent a flit after every packet had arrived");
        errors++;
      end
    end

    $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- test/router_tests.mem
// Columns: input port, dest x, dest y, payload length, stall mode, packet count (hex).
// Ports 0 XP, 1 XM, 2 YP, 3 YM, 4 LOCAL. Stall 0 ready, 1 random ready, 2 long stall.
// Routing from the local port, router at (1,1)
4 2 1 03 0 1
4 0 1 03 0 1
4 1 2 03 0 1
4 1 0 03 0 1
4 1 1 03 0 1
// Routing from the neighbour ports
0 0 2 02 0 1
1 3 0 04 0 1
2 1 0 02 0 1
3 1 3 05 0 1
0 1 1 01 0 1
2 3 3 00 0 1
3 0 0 06 0 1
1 1 2 02 0 1
// Several inputs contend for one output
0 1 1 04 0 3
1 2 2 05 0 4
2 1 3 03 0 5
4 0 1 06 0 3
// Random back-pressure
4 2 0 08 1 1
0 1 1 07 1 3
3 0 3 0a 1 5
1 1 0 05 1 2
// Output stalled long enough to fill the input FIFO
4 1 2 0c 2 1
1 1 1 10 2 2
2 3 1 0e 2 1

//--- tb.f
src/noc_pkg.sv
src/noc_input_port.sv
src/noc_output_arbiter.sv
src/noc_output_stage.sv
src/noc_router.sv
test/noc_router_props.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the router testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module tb_top -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
